// File: hw/cmd_dispatch.sv
`default_nettype none

module cmd_dispatch (
    input wire clk,
    input wire reset,
    input wire panel_types_pkg::data_byte_t data_in,
    input wire enable,
    output logic ready_for_data,
    output logic cmd_done,
    output logic fill_start,
    output logic setpixel_start,
    output logic byte_valid,
    output panel_types_pkg::data_byte_t byte_data,
    input wire fill_ready,
    input wire fill_done,
    input wire setpixel_ready,
    input wire setpixel_done
);
    panel_cmd_pkg::dispatch_state_t state;
    logic active_fill; // which engine owns the current command
    logic opcode_strobe;

    assign opcode_strobe = enable && (state == panel_cmd_pkg::IDLE);
    assign fill_start = opcode_strobe && (data_in == panel_cmd_pkg::OP_FILL_PANEL);
    assign setpixel_start = opcode_strobe && (data_in == panel_cmd_pkg::OP_SET_PIXEL);

    // payload bytes go to both engines, only the one that was started takes them
    assign byte_valid = enable && (state == panel_cmd_pkg::BUSY);
    assign byte_data = data_in;

    always_comb begin
        if (state == panel_cmd_pkg::IDLE) begin
            ready_for_data = 1'b1;
            cmd_done = 1'b0;
        end else begin
            ready_for_data = active_fill ? fill_ready : setpixel_ready;
            cmd_done = active_fill ? fill_done : setpixel_done;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= panel_cmd_pkg::IDLE;
            active_fill <= 1'b0;
        end else begin
            case (state)
                panel_cmd_pkg::IDLE: begin
                    if (fill_start || setpixel_start) begin // unknown opcodes are dropped here
                        state <= panel_cmd_pkg::BUSY;
                        active_fill <= fill_start;
                    end
                end
                panel_cmd_pkg::BUSY: begin
                    if (cmd_done) state <= panel_cmd_pkg::IDLE;
                end
                default: state <= panel_cmd_pkg::IDLE;
            endcase
        end
    end
endmodule

`default_nettype wire

// File: hw/cmd_fillpanel.sv
`default_nettype none

`include "panel_defines.svh"

module cmd_fillpanel (
    input wire clk,
    input wire reset,
    input wire start,
    input wire byte_valid,
    input wire panel_types_pkg::data_byte_t byte_data,
    output logic ready,
    output logic done,
    fb_port_if.requester fb
);
    panel_cmd_pkg::fill_state_t state;
    panel_types_pkg::color_t fill_color;
    panel_types_pkg::pixel_sel_t bytes_left;
    logic walker_enable;
    logic walker_done;
    logic local_reset; // returns the walker to the first pixel once a fill ends

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= panel_cmd_pkg::FILL_IDLE;
            fill_color <= '0;
            bytes_left <= panel_types_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1);
            ready <= 1'b1;
            done <= 1'b0;
            walker_enable <= 1'b0;
            local_reset <= 1'b0;
        end else begin
            case (state)
                panel_cmd_pkg::FILL_IDLE: begin
                    if (start) begin
                        state <= panel_cmd_pkg::FILL_CAPTURE;
                        bytes_left <= panel_types_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1);
                    end
                end
                panel_cmd_pkg::FILL_CAPTURE: begin
                    if (byte_valid) begin
                        fill_color[bytes_left*8 +: 8] <= byte_data; // red arrives first
                        if (bytes_left == 0) begin
                            state <= panel_cmd_pkg::FILL_START;
                            ready <= 1'b0;
                        end else begin
                            bytes_left <= bytes_left - 1'b1;
                        end
                    end
                end
                panel_cmd_pkg::FILL_START: begin
                    walker_enable <= 1'b1;
                    state <= panel_cmd_pkg::FILL_RUN;
                end
                panel_cmd_pkg::FILL_RUN: begin
                    if (walker_done) begin
                        walker_enable <= 1'b0;
                        local_reset <= 1'b1;
                        state <= panel_cmd_pkg::FILL_PREDONE;
                    end
                end
                panel_cmd_pkg::FILL_PREDONE: begin
                    local_reset <= 1'b0;
                    done <= 1'b1;
                    state <= panel_cmd_pkg::FILL_DONE;
                end
                panel_cmd_pkg::FILL_DONE: begin
                    done <= 1'b0;
                    ready <= 1'b1;
                    fill_color <= '0;
                    state <= panel_cmd_pkg::FILL_IDLE;
                end
                default: state <= panel_cmd_pkg::FILL_IDLE;
            endcase
        end
    end

    fill_area_walker walker_i (
        .clk(clk),
        .reset(reset || local_reset),
        .enable(walker_enable),
        .color(fill_color),
        .done(walker_done),
        .fb(fb)
    );
endmodule

`default_nettype wire

// File: hw/cmd_setpixel.sv
`default_nettype none

`include "panel_defines.svh"

module cmd_setpixel (
    input wire clk,
    input wire reset,
    input wire start,
    input wire byte_valid,
    input wire panel_types_pkg::data_byte_t byte_data,
    output logic ready,
    output logic done,
    fb_port_if.requester fb
);
    panel_cmd_pkg::setpixel_state_t state;
    panel_types_pkg::row_t row_q;
    panel_types_pkg::column_t column_q;
    panel_types_pkg::pixel_sel_t pixel_q;
    panel_types_pkg::pixel_sel_t bytes_left;
    panel_types_pkg::color_t pixel_color;

    assign fb.req = (state == panel_cmd_pkg::SP_WRITE);
    assign fb.write_enable = 1'b1;
    assign fb.row = row_q;
    assign fb.column = column_q;
    assign fb.pixel = pixel_q;
    assign fb.data_out = pixel_color[(`BYTES_PER_PIXEL - 1 - pixel_q) * 8 +: 8];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= panel_cmd_pkg::SP_IDLE;
            ready <= 1'b1;
            done <= 1'b0;
            pixel_q <= '0;
            bytes_left <= '0;
        end else begin
            case (state)
                panel_cmd_pkg::SP_IDLE: begin
                    if (start) state <= panel_cmd_pkg::SP_ROW;
                end
                panel_cmd_pkg::SP_ROW: begin
                    if (byte_valid) state <= panel_cmd_pkg::SP_COLUMN;
                end
                panel_cmd_pkg::SP_COLUMN: begin
                    if (byte_valid) begin
                        state <= panel_cmd_pkg::SP_COLOR;
                        bytes_left <= panel_types_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1);
                    end
                end
                panel_cmd_pkg::SP_COLOR: begin
                    if (byte_valid) begin
                        if (bytes_left == 0) begin
                            state <= panel_cmd_pkg::SP_WRITE;
                            ready <= 1'b0;
                            pixel_q <= '0;
                        end else begin
                            bytes_left <= bytes_left - 1'b1;
                        end
                    end
                end
                panel_cmd_pkg::SP_WRITE: begin
                    if (fb.grant) begin
                        if (pixel_q == panel_types_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1)) begin
                            state <= panel_cmd_pkg::SP_DONE;
                            done <= 1'b1;
                        end else begin
                            pixel_q <= pixel_q + 1'b1;
                        end
                    end
                end
                panel_cmd_pkg::SP_DONE: begin
                    done <= 1'b0;
                    ready <= 1'b1;
                    state <= panel_cmd_pkg::SP_IDLE;
                end
                default: state <= panel_cmd_pkg::SP_IDLE;
            endcase
        end
    end

    // address and colour registers only load while their byte is expected
    always_ff @(posedge clk) begin
        if (byte_valid && state == panel_cmd_pkg::SP_ROW)
            row_q <= panel_types_pkg::row_t'(byte_data % `PANEL_HEIGHT); // wraps large rows
        if (byte_valid && state == panel_cmd_pkg::SP_COLUMN)
            column_q <= panel_types_pkg::column_t'(byte_data % `PANEL_WIDTH);
        if (byte_valid && state == panel_cmd_pkg::SP_COLOR)
            pixel_color[bytes_left*8 +: 8] <= byte_data;
    end
endmodule

`default_nettype wire

// File: hw/fb_arbiter.sv
`default_nettype none

module fb_arbiter (
    input wire clk,
    input wire reset,
    fb_port_if.arbiter rd_port,
    fb_port_if.arbiter set_port,
    fb_port_if.arbiter fill_port,
    fb_port_if.requester mem
);
    logic [2:0] read_owner; // one-hot {readback, setpixel, fill} of the read in flight

    // readback wins over set pixel, set pixel wins over fill
    assign rd_port.grant = rd_port.req && mem.grant;
    assign set_port.grant = set_port.req && !rd_port.req && mem.grant;
    assign fill_port.grant = fill_port.req && !rd_port.req && !set_port.req && mem.grant;

    assign mem.req = rd_port.req || set_port.req || fill_port.req;

    always_comb begin
        if (rd_port.req) begin
            mem.write_enable = rd_port.write_enable;
            mem.row = rd_port.row;
            mem.column = rd_port.column;
            mem.pixel = rd_port.pixel;
            mem.data_out = rd_port.data_out;
        end else if (set_port.req) begin
            mem.write_enable = set_port.write_enable;
            mem.row = set_port.row;
            mem.column = set_port.column;
            mem.pixel = set_port.pixel;
            mem.data_out = set_port.data_out;
        end else begin
            mem.write_enable = fill_port.write_enable;
            mem.row = fill_port.row;
            mem.column = fill_port.column;
            mem.pixel = fill_port.pixel;
            mem.data_out = fill_port.data_out;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            read_owner <= '0;
        end else begin
            read_owner <= {rd_port.grant && !rd_port.write_enable,
                           set_port.grant && !set_port.write_enable,
                           fill_port.grant && !fill_port.write_enable};
        end
    end

    // read data shows up the cycle after the grant, so route it by the registered owner
    assign rd_port.data_in = read_owner[2] ? mem.data_in : '0;
    assign set_port.data_in = read_owner[1] ? mem.data_in : '0;
    assign fill_port.data_in = read_owner[0] ? mem.data_in : '0;
endmodule

`default_nettype wire

// File: hw/fb_port_if.sv
`default_nettype none

// one access path to the frame buffer, an access happens on a rising edge with req and grant high
interface fb_port_if;
    logic req;
    logic grant;
    logic write_enable;
    panel_types_pkg::row_t row;
    panel_types_pkg::column_t column;
    panel_types_pkg::pixel_sel_t pixel;
    panel_types_pkg::data_byte_t data_out; // write data toward the memory
    panel_types_pkg::data_byte_t data_in;  // read data back from the memory

    modport requester (
        output req, write_enable, row, column, pixel, data_out,
        input grant, data_in
    );

    modport arbiter (
        input req, write_enable, row, column, pixel, data_out,
        output grant, data_in
    );

    modport memory (
        input req, write_enable, row, column, pixel, data_out,
        output grant, data_in
    );
endinterface

`default_nettype wire

// File: hw/fill_area_walker.sv
`default_nettype none

`include "panel_defines.svh"

module fill_area_walker (
    input wire clk,
    input wire reset,
    input wire enable,
    input wire panel_types_pkg::color_t color,
    output logic done,
    fb_port_if.requester fb
);
    panel_types_pkg::row_t row_q;
    panel_types_pkg::column_t column_q;
    panel_types_pkg::pixel_sel_t pixel_q;
    logic last_pixel_byte;
    logic last_column;
    logic last_row;

    assign last_pixel_byte = (pixel_q == panel_types_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1));
    assign last_column = (column_q == panel_types_pkg::column_t'(`PANEL_WIDTH - 1));
    assign last_row = (row_q == panel_types_pkg::row_t'(`PANEL_HEIGHT - 1));

    assign fb.req = enable && !done;
    assign fb.write_enable = 1'b1;
    assign fb.row = row_q;
    assign fb.column = column_q;
    assign fb.pixel = pixel_q;
    // select 0 picks the top byte of the colour
    assign fb.data_out = color[(`BYTES_PER_PIXEL - 1 - pixel_q) * 8 +: 8];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            row_q <= '0;
            column_q <= '0;
            pixel_q <= '0;
            done <= 1'b0;
        end else if (fb.req && fb.grant) begin // counters hold while another port has the memory
            if (!last_pixel_byte) begin
                pixel_q <= pixel_q + 1'b1;
            end else begin
                pixel_q <= '0;
                if (!last_column) begin
                    column_q <= column_q + 1'b1;
                end else begin
                    column_q <= '0;
                    if (last_row) begin
                        done <= 1'b1;
                    end else begin
                        row_q <= row_q + 1'b1;
                    end
                end
            end
        end
    end
endmodule

`default_nettype wire

// File: hw/frame_buffer.sv
`default_nettype none

`include "panel_defines.svh"

module frame_buffer (
    input wire clk,
    fb_port_if.memory mem
);
    logic [7:0] store [`PANEL_HEIGHT][`PANEL_WIDTH][`BYTES_PER_PIXEL];
    logic access;

    // single port with no wait states, every request is served at once
    assign mem.grant = mem.req;
    assign access = mem.req && mem.grant;

    always_ff @(posedge clk) begin
        if (access) begin
            if (mem.write_enable) begin
                store[mem.row][mem.column][mem.pixel] <= mem.data_out;
            end else begin
                mem.data_in <= store[mem.row][mem.column][mem.pixel];
            end
        end
    end
endmodule

`default_nettype wire

// File: hw/panel_cmd_pkg.sv
`default_nettype none

package panel_cmd_pkg;

    typedef enum logic [7:0] {
        OP_FILL_PANEL = 8'h01,
        OP_SET_PIXEL = 8'h02
    } cmd_opcode_t;

    typedef enum logic {IDLE, BUSY} dispatch_state_t;

    typedef enum logic [2:0] {
        FILL_IDLE,
        FILL_CAPTURE,
        FILL_START,
        FILL_RUN,
        FILL_PREDONE,
        FILL_DONE
    } fill_state_t;

    typedef enum logic [2:0] {
        SP_IDLE,
        SP_ROW,
        SP_COLUMN,
        SP_COLOR,
        SP_WRITE,
        SP_DONE
    } setpixel_state_t;

endpackage

`default_nettype wire

// File: hw/panel_ctrl_top.sv
`default_nettype none

module panel_ctrl_top (
    input wire clk,
    input wire reset,
    input wire panel_types_pkg::data_byte_t data_in,
    input wire enable,
    input wire rd_req,
    input wire panel_types_pkg::row_t rd_row,
    input wire panel_types_pkg::column_t rd_column,
    input wire panel_types_pkg::pixel_sel_t rd_pixel,
    output logic ready_for_data,
    output logic cmd_done,
    output logic rd_valid,
    output panel_types_pkg::data_byte_t rd_data
);
    logic fill_start;
    logic setpixel_start;
    logic byte_valid;
    panel_types_pkg::data_byte_t byte_data;
    logic fill_ready;
    logic fill_done;
    logic setpixel_ready;
    logic setpixel_done;

    fb_port_if rd_if ();
    fb_port_if set_if ();
    fb_port_if fill_if ();
    fb_port_if mem_if ();

    // the request drops while rd_valid is up so one host request gives one read
    assign rd_if.req = rd_req && !rd_valid;
    assign rd_if.write_enable = 1'b0;
    assign rd_if.row = rd_row;
    assign rd_if.column = rd_column;
    assign rd_if.pixel = rd_pixel;
    assign rd_if.data_out = '0;
    assign rd_data = rd_if.data_in;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) rd_valid <= 1'b0;
        else rd_valid <= rd_if.grant;
    end

    cmd_dispatch dispatch_i (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .enable(enable),
        .ready_for_data(ready_for_data),
        .cmd_done(cmd_done),
        .fill_start(fill_start),
        .setpixel_start(setpixel_start),
        .byte_valid(byte_valid),
        .byte_data(byte_data),
        .fill_ready(fill_ready),
        .fill_done(fill_done),
        .setpixel_ready(setpixel_ready),
        .setpixel_done(setpixel_done)
    );

    cmd_fillpanel fillpanel_i (
        .clk(clk),
        .reset(reset),
        .start(fill_start),
        .byte_valid(byte_valid),
        .byte_data(byte_data),
        .ready(fill_ready),
        .done(fill_done),
        .fb(fill_if.requester)
    );

    cmd_setpixel setpixel_i (
        .clk(clk),
        .reset(reset),
        .start(setpixel_start),
        .byte_valid(byte_valid),
        .byte_data(byte_data),
        .ready(setpixel_ready),
        .done(setpixel_done),
        .fb(set_if.requester)
    );

    fb_arbiter arbiter_i (
        .clk(clk),
        .reset(reset),
        .rd_port(rd_if.arbiter),
        .set_port(set_if.arbiter),
        .fill_port(fill_if.arbiter),
        .mem(mem_if.requester)
    );

    frame_buffer frame_buffer_i (
        .clk(clk),
        .mem(mem_if.memory)
    );
endmodule

`default_nettype wire

// File: hw/panel_types_pkg.sv
`default_nettype none

`include "panel_defines.svh"

package panel_types_pkg;

    typedef logic [$clog2(`PANEL_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`PANEL_WIDTH)-1:0] column_t;

    // byte 0 of a pixel is the most significant colour byte (red)
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_sel_t;

    typedef logic [7:0] data_byte_t;
    typedef logic [(`BYTES_PER_PIXEL*8)-1:0] color_t;

endpackage

`default_nettype wire

// File: include/panel_defines.svh
`ifndef PANEL_DEFINES_SVH
`define PANEL_DEFINES_SVH

// panel geometry in pixels
`define PANEL_WIDTH 16
`define PANEL_HEIGHT 8

// one byte each for red, green and blue
`define BYTES_PER_PIXEL 3

`endif

// File: run_sim.sh
#!/bin/sh
# compiles the panel controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module panel_ctrl_tb \
    -o panel_ctrl_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/panel_ctrl_sim > "$SIM_LOG" 2>&1
run_status=$?

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    echo "test failures found in $SIM_LOG"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status, see $SIM_LOG"
    exit 1
fi

echo "run finished cleanly, log in $SIM_LOG"
exit 0

// File: verification/panel_ctrl_tb.sv
`default_nettype none

`include "panel_defines.svh"

module panel_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FILL_CYCLES = `PANEL_WIDTH * `PANEL_HEIGHT * `BYTES_PER_PIXEL + 3;
    localparam int READY_TIMEOUT = 1000;
    localparam int READ_TIMEOUT = 20;
    localparam int DONE_TIMEOUT = 4000;

    logic clk;
    logic reset;
    panel_types_pkg::data_byte_t data_in;
    logic enable;
    logic rd_req;
    panel_types_pkg::row_t rd_row;
    panel_types_pkg::column_t rd_column;
    panel_types_pkg::pixel_sel_t rd_pixel;
    logic ready_for_data;
    logic cmd_done;
    logic rd_valid;
    panel_types_pkg::data_byte_t rd_data;

    // expected frame buffer contents once the first fill has run
    panel_types_pkg::data_byte_t model [`PANEL_HEIGHT][`PANEL_WIDTH][`BYTES_PER_PIXEL];

    panel_ctrl_top panel_ctrl_top_i (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .enable(enable),
        .rd_req(rd_req),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .ready_for_data(ready_for_data),
        .cmd_done(cmd_done),
        .rd_valid(rd_valid),
        .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0d ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_byte(input string name, input panel_types_pkg::data_byte_t actual,
                              input panel_types_pkg::data_byte_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %b, expected %b",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // red goes to select 0, blue to the last select
    function automatic panel_types_pkg::data_byte_t color_byte(input panel_types_pkg::color_t color,
                                                               input int sel);
        return panel_types_pkg::data_byte_t'(color >> (8 * (`BYTES_PER_PIXEL - 1 - sel)));
    endfunction

    task automatic model_fill(input panel_types_pkg::color_t color);
        for (int r = 0; r < `PANEL_HEIGHT; r++)
            for (int c = 0; c < `PANEL_WIDTH; c++)
                for (int s = 0; s < `BYTES_PER_PIXEL; s++)
                    model[r][c][s] = color_byte(color, s);
    endtask

    // every task starts and ends 2 ns after a rising edge
    task automatic send_byte(input panel_types_pkg::data_byte_t value);
        int cycles;
        cycles = 0;
        while (!ready_for_data && cycles < READY_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!ready_for_data) report_timeout("ready_for_data never came back high");
        data_in = value;
        enable = 1'b1;
        @(posedge clk); // the byte is taken on this edge
        #2;
        enable = 1'b0;
    endtask

    task automatic read_byte(input int row, input int column, input int sel,
                             output panel_types_pkg::data_byte_t value);
        int cycles;
        cycles = 0;
        rd_row = panel_types_pkg::row_t'(row);
        rd_column = panel_types_pkg::column_t'(column);
        rd_pixel = panel_types_pkg::pixel_sel_t'(sel);
        rd_req = 1'b1;
        @(posedge clk);
        #2;
        while (!rd_valid && cycles < READ_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!rd_valid) report_timeout("rd_valid never rose for a readback");
        value = rd_data;
        rd_req = 1'b0;
    endtask

    task automatic wait_cmd_done(output int cycles);
        cycles = 0;
        while (!cmd_done && cycles < DONE_TIMEOUT) begin
            check_flag("ready_for_data", ready_for_data, 1'b0); // busy until the done pulse
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!cmd_done) report_timeout("cmd_done never pulsed");
        check_flag("ready_for_data", ready_for_data, 1'b0);
        @(posedge clk);
        #2;
        check_flag("cmd_done", cmd_done, 1'b0);
        check_flag("ready_for_data", ready_for_data, 1'b1);
    endtask

    task automatic send_fill_bytes(input panel_types_pkg::color_t color);
        send_byte(panel_cmd_pkg::OP_FILL_PANEL);
        for (int s = 0; s < `BYTES_PER_PIXEL; s++)
            send_byte(color_byte(color, s));
        check_flag("ready_for_data", ready_for_data, 1'b0);
    endtask

    task automatic send_setpixel_bytes(input panel_types_pkg::data_byte_t row_byte,
                                       input panel_types_pkg::data_byte_t column_byte,
                                       input panel_types_pkg::color_t color);
        send_byte(panel_cmd_pkg::OP_SET_PIXEL);
        send_byte(row_byte);
        send_byte(column_byte);
        for (int s = 0; s < `BYTES_PER_PIXEL; s++)
            send_byte(color_byte(color, s));
        check_flag("ready_for_data", ready_for_data, 1'b0);
    endtask

    task automatic verify_pixel(input int row, input int column);
        panel_types_pkg::data_byte_t got;
        for (int s = 0; s < `BYTES_PER_PIXEL; s++) begin
            read_byte(row, column, s, got);
            check_byte($sformatf("rd_data[%0d][%0d][%0d]", row, column, s), got, model[row][column][s]);
        end
    endtask

    task automatic verify_panel();
        for (int r = 0; r < `PANEL_HEIGHT; r++)
            for (int c = 0; c < `PANEL_WIDTH; c++)
                verify_pixel(r, c);
    endtask

    // out of range coordinates wrap around the panel
    task automatic set_and_verify_pixel(input panel_types_pkg::data_byte_t row_byte,
                                        input panel_types_pkg::data_byte_t column_byte);
        panel_types_pkg::color_t color;
        int row;
        int column;
        int cycles;
        color = panel_types_pkg::color_t'($urandom);
        row = row_byte % `PANEL_HEIGHT;
        column = column_byte % `PANEL_WIDTH;
        send_setpixel_bytes(row_byte, column_byte, color);
        wait_cmd_done(cycles);
        check_count("set pixel latency", cycles, `BYTES_PER_PIXEL);
        for (int s = 0; s < `BYTES_PER_PIXEL; s++)
            model[row][column][s] = color_byte(color, s);
        verify_pixel(row, column);
        verify_pixel((row + 1) % `PANEL_HEIGHT, column);
        verify_pixel(row, (column + 1) % `PANEL_WIDTH);
    endtask

    task automatic test_reset_state();
        check_flag("ready_for_data", ready_for_data, 1'b1);
        check_flag("cmd_done", cmd_done, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
    endtask

    task automatic test_fill();
        panel_types_pkg::color_t color;
        int cycles;
        color = panel_types_pkg::color_t'($urandom);
        send_fill_bytes(color);
        wait_cmd_done(cycles);
        check_count("fill latency", cycles, FILL_CYCLES); // no readbacks compete here
        model_fill(color);
        verify_panel();
    endtask

    task automatic test_setpixel_after_fill();
        set_and_verify_pixel(panel_types_pkg::data_byte_t'($urandom),
                             panel_types_pkg::data_byte_t'($urandom));
    endtask

    task automatic test_reads_during_fill();
        panel_types_pkg::color_t color;
        panel_types_pkg::data_byte_t got;
        int cycles;
        int gap;
        int row;
        int column;
        int sel;
        color = panel_types_pkg::color_t'($urandom);
        send_fill_bytes(color);
        fork
            wait_cmd_done(cycles);
            begin
                for (int i = 0; i < 24; i++) begin
                    row = $urandom_range(`PANEL_HEIGHT - 1);
                    column = $urandom_range(`PANEL_WIDTH - 1);
                    sel = $urandom_range(`BYTES_PER_PIXEL - 1);
                    read_byte(row, column, sel, got);
                    // a byte the walker has not reached yet still holds its old value
                    if (got !== color_byte(color, sel))
                        check_byte($sformatf("rd_data[%0d][%0d][%0d]", row, column, sel),
                                   got, model[row][column][sel]);
                    gap = $urandom_range(3);
                    repeat (gap) begin
                        @(posedge clk);
                        #2;
                    end
                end
            end
        join
        model_fill(color);
        verify_panel();
    endtask

    task automatic test_unknown_opcode();
        panel_types_pkg::data_byte_t opcode;
        opcode = panel_types_pkg::data_byte_t'($urandom);
        while (opcode == panel_cmd_pkg::OP_FILL_PANEL || opcode == panel_cmd_pkg::OP_SET_PIXEL)
            opcode = panel_types_pkg::data_byte_t'($urandom);
        send_byte(opcode);
        repeat (4) begin
            check_flag("cmd_done", cmd_done, 1'b0);
            check_flag("ready_for_data", ready_for_data, 1'b1);
            @(posedge clk);
            #2;
        end
        set_and_verify_pixel(panel_types_pkg::data_byte_t'($urandom_range(`PANEL_HEIGHT - 1)),
                             panel_types_pkg::data_byte_t'($urandom_range(`PANEL_WIDTH - 1)));
    endtask

    initial begin
        void'($urandom(91754));
        reset = 1'b1;
        data_in = '0;
        enable = 1'b0;
        rd_req = 1'b0;
        rd_row = '0;
        rd_column = '0;
        rd_pixel = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;

        // ready dropping and returning is checked inside every command
        test_reset_state();
        test_fill();
        test_setpixel_after_fill();
        test_reads_during_fill();
        test_unknown_opcode();

        $display("SIMULATION PASSED");
        $finish;
    end
endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hw/panel_types_pkg.sv
hw/panel_cmd_pkg.sv
hw/fb_port_if.sv
hw/frame_buffer.sv
hw/fb_arbiter.sv
hw/fill_area_walker.sv
hw/cmd_fillpanel.sv
hw/cmd_setpixel.sv
hw/cmd_dispatch.sv
hw/panel_ctrl_top.sv
verification/panel_ctrl_tb.sv
